/* source/matrixPkg.sv */
package matrixPkg;

    ////////////////////
    // Sizes and widths
    ////////////////////

    // Command and data words
    localparam int wordWidth = 32;

    // Program memory depth in words
    localparam int memDepth = 64;
    localparam int memAddrWidth = $clog2(memDepth);

    // Sequencer addresses are byte addresses
    localparam int byteAddrWidth = memAddrWidth + 2;

    // Rows and columns of one matrix
    localparam int matrixDim = 4;

    // Program counter steps
    localparam logic [byteAddrWidth-1:0] cmdBytes = byteAddrWidth'(4);
    // One column of a LoadMatrix payload
    localparam logic [byteAddrWidth-1:0] columnBytes = byteAddrWidth'(16);
    // Command word plus sixteen data words
    localparam logic [byteAddrWidth-1:0] loadMatrixBytes =
        byteAddrWidth'(4 * (1 + matrixDim * matrixDim));

    // IEEE 754 single precision 1.0
    localparam logic [wordWidth-1:0] floatOne = 32'h3F800000;

    ////////////////////
    // Command encoding
    ////////////////////

    // Low byte of a command word
    typedef enum logic [7:0] {
        opHalt         = 8'h00,
        opMatrixMode   = 8'h10,   // bit 8 picks the matrix
        opLoadIdentity = 8'h11,
        opLoadMatrix   = 8'h13    // bit 31 set by convention, ignored
    } opcode_e;

    // Which matrix a command targets
    typedef enum logic {
        selModelview  = 1'b0,
        selProjection = 1'b1
    } matrixSel_e;

    ////////////////////
    // Sequencer states
    ////////////////////

    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stLoadColumn,
        stIdentityColumn,
        stHalted
    } seqState_e;

endpackage

/* source/matrixWriteIf.sv */
interface matrixWriteIf import matrixPkg::*; ();

    // One strobe, one full column
    logic writeEn;

    // Target matrix
    matrixSel_e matrixSel;

    // Column index within the matrix
    logic [1:0] column;

    // Column payload, entry 0 is row 0
    logic [matrixDim-1:0][wordWidth-1:0] colData;

    ////////////////////
    // Modports
    ////////////////////

    // Command side drives the write
    modport sequencer (
        output writeEn,
        output matrixSel,
        output column,
        output colData
    );

    // Storage side takes it
    modport bank (
        input writeEn,
        input matrixSel,
        input column,
        input colData
    );

endinterface

/* source/commandMemory.sv */
module commandMemory import matrixPkg::*; (
    input  logic                                clk,

    // Host load port, word addressed
    input  logic                                progWrite,
    input  logic [memAddrWidth-1:0]             progAddr,
    input  logic [wordWidth-1:0]                progData,

    // Sequencer read addresses, byte addressed
    input  logic [byteAddrWidth-1:0]            cmdAddr,
    input  logic [byteAddrWidth-1:0]            dataAddr,

    // Read data
    output logic [wordWidth-1:0]                cmdWord,
    output logic [matrixDim-1:0][wordWidth-1:0] dataWords
);

    // Program storage
    logic [wordWidth-1:0] mem [memDepth];

    // Word addresses after dropping the byte offset
    logic [memAddrWidth-1:0] cmdIndex;
    logic [memAddrWidth-1:0] dataBase;

    ////////////////////
    // Host write
    ////////////////////

    // Accepted any cycle
    always_ff @(posedge clk) begin
        if (progWrite) begin
            mem[progAddr] <= progData;
        end
    end

    ////////////////////
    // Read ports
    ////////////////////

    // Low two bits are the byte offset
    assign cmdIndex = cmdAddr[byteAddrWidth-1:2];
    assign dataBase = dataAddr[byteAddrWidth-1:2];

    // Single command word
    assign cmdWord = mem[cmdIndex];

    // Four consecutive words, index math wraps at memDepth
    for (genvar i = 0; i < matrixDim; i++) begin : gDataRead
        assign dataWords[i] = mem[dataBase + memAddrWidth'(i)];
    end

endmodule

/* source/commandSequencer.sv */
module commandSequencer import matrixPkg::*; (
    input  logic                                clk,
    input  logic                                arstN,

    // Host control
    input  logic                                start,

    // Memory read data
    input  logic [wordWidth-1:0]                cmdWord,
    input  logic [matrixDim-1:0][wordWidth-1:0] dataWords,

    // Memory read addresses, byte addressed
    output logic [byteAddrWidth-1:0]            cmdAddr,
    output logic [byteAddrWidth-1:0]            dataAddr,

    // Status
    output logic                                busy,
    output logic                                done,
    output logic                                illegalOp,

    // Column writes into the bank
    matrixWriteIf.sequencer                     writePort
);

    // Control state
    seqState_e               state;
    logic [byteAddrWidth-1:0] pc;
    matrixSel_e              curSel;
    logic [1:0]              colCount;

    // Decoded command fields
    opcode_e                 opcode;
    matrixSel_e              modeSel;

    // Start is only taken when not running
    logic                    startAccept;
    logic                    lastColumn;

    ////////////////////
    // Decode
    ////////////////////

    assign opcode  = opcode_e'(cmdWord[7:0]);
    // MatrixMode operand
    assign modeSel = matrixSel_e'(cmdWord[8]);

    assign startAccept = start && (state == stIdle || state == stHalted);
    assign lastColumn  = (colCount == 2'd3);

    // Command word sits at the program counter
    assign cmdAddr = pc;

    // Payload column c starts 4 + 16c bytes past the command
    assign dataAddr = pc + cmdBytes + (columnBytes * colCount);

    // Running in any active state
    assign busy = (state == stFetch) || (state == stLoadColumn) ||
                  (state == stIdentityColumn);

    ////////////////////
    // State machine
    ////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= stIdle;
            pc        <= '0;
            curSel    <= selModelview;
            colCount  <= '0;
            done      <= 1'b0;
            illegalOp <= 1'b0;
        end else begin
            // Done is a single cycle pulse
            done <= 1'b0;

            case (state)
                stIdle, stHalted: begin
                    if (startAccept) begin
                        state     <= stFetch;
                        pc        <= '0;
                        colCount  <= '0;
                        illegalOp <= 1'b0;
                    end
                end

                stFetch: begin
                    case (opcode)
                        opMatrixMode: begin
                            curSel <= modeSel;
                            pc     <= pc + cmdBytes;
                        end
                        opLoadMatrix: begin
                            state    <= stLoadColumn;
                            colCount <= '0;
                        end
                        opLoadIdentity: begin
                            state    <= stIdentityColumn;
                            colCount <= '0;
                        end
                        opHalt: begin
                            state <= stHalted;
                            done  <= 1'b1;
                        end
                        default: begin
                            // Unknown opcode stops like Halt
                            state     <= stHalted;
                            done      <= 1'b1;
                            illegalOp <= 1'b1;
                        end
                    endcase
                end

                stLoadColumn: begin
                    colCount <= colCount + 2'd1;
                    // Skip command and payload
                    if (lastColumn) begin
                        state <= stFetch;
                        pc    <= pc + loadMatrixBytes;
                    end
                end

                stIdentityColumn: begin
                    colCount <= colCount + 2'd1;
                    if (lastColumn) begin
                        state <= stFetch;
                        pc    <= pc + cmdBytes;
                    end
                end

                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    ////////////////////
    // Bank write
    ////////////////////

    // One column per cycle in either write state
    assign writePort.writeEn   = (state == stLoadColumn) || (state == stIdentityColumn);
    assign writePort.matrixSel = curSel;
    assign writePort.column    = colCount;

    // Payload words or an identity column
    always_comb begin
        for (int r = 0; r < matrixDim; r++) begin
            if (state == stLoadColumn) begin
                writePort.colData[r] = dataWords[r];
            end else if (r == int'(colCount)) begin
                writePort.colData[r] = floatOne;
            end else begin
                writePort.colData[r] = '0;
            end
        end
    end

endmodule

/* source/matrixBank.sv */
module matrixBank import matrixPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,

    // Element readback select
    input  matrixSel_e           rdSel,
    input  logic [1:0]           rdRow,
    input  logic [1:0]           rdCol,

    // Column writes from the sequencer
    matrixWriteIf.bank           writePort,

    // Selected element
    output logic [wordWidth-1:0] rdData
);

    // Two matrices, indexed [matrix][row][column]
    logic [wordWidth-1:0] mats [2][matrixDim][matrixDim];

    // Write target
    logic                 wrMat;
    logic [1:0]           wrCol;

    assign wrMat = writePort.matrixSel;
    assign wrCol = writePort.column;

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // Both matrices start at zero
            for (int m = 0; m < 2; m++) begin
                for (int r = 0; r < matrixDim; r++) begin
                    for (int c = 0; c < matrixDim; c++) begin
                        mats[m][r][c] <= '0;
                    end
                end
            end
        end else if (writePort.writeEn) begin
            // Whole column in one cycle
            for (int r = 0; r < matrixDim; r++) begin
                mats[wrMat][r][wrCol] <= writePort.colData[r];
            end
        end
    end

    ////////////////////
    // Readback
    ////////////////////

    // Combinational, sees a column right after its write edge
    assign rdData = mats[rdSel][rdRow][rdCol];

endmodule

/* source/matrixUnitTop.sv */
module matrixUnitTop import matrixPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,

    // Program load
    input  logic                    progWrite,
    input  logic [memAddrWidth-1:0] progAddr,
    input  logic [wordWidth-1:0]    progData,

    // Run control
    input  logic                    start,
    output logic                    busy,
    output logic                    done,
    output logic                    illegalOp,

    // Matrix readback
    input  matrixSel_e              rdSel,
    input  logic [1:0]              rdRow,
    input  logic [1:0]              rdCol,
    output logic [wordWidth-1:0]    rdData
);

    // Memory to sequencer
    logic [byteAddrWidth-1:0]            cmdAddr;
    logic [byteAddrWidth-1:0]            dataAddr;
    logic [wordWidth-1:0]                cmdWord;
    logic [matrixDim-1:0][wordWidth-1:0] dataWords;

    // Sequencer to bank
    matrixWriteIf writeBus ();

    ////////////////////
    // Instances
    ////////////////////

    commandMemory uMemory (
        .clk       (clk),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .cmdAddr   (cmdAddr),
        .dataAddr  (dataAddr),
        .cmdWord   (cmdWord),
        .dataWords (dataWords)
    );

    commandSequencer uSequencer (
        .clk       (clk),
        .arstN     (arstN),
        .start     (start),
        .cmdWord   (cmdWord),
        .dataWords (dataWords),
        .cmdAddr   (cmdAddr),
        .dataAddr  (dataAddr),
        .busy      (busy),
        .done      (done),
        .illegalOp (illegalOp),
        .writePort (writeBus.sequencer)
    );

    matrixBank uBank (
        .clk       (clk),
        .arstN     (arstN),
        .rdSel     (rdSel),
        .rdRow     (rdRow),
        .rdCol     (rdCol),
        .writePort (writeBus.bank),
        .rdData    (rdData)
    );

endmodule

/* bench/matrixUnit_asserts.sv */
module matrixUnitAsserts (
    input logic clk,
    input logic arstN,
    input logic busy,
    input logic done,
    input logic illegalOp,
    input logic writeEn
);

    // Number of failed assertions
    int failCount = 0;

    ////////////////////
    // Sequencer control
    ////////////////////

    // Done is a single cycle pulse
    donePulse: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
        else begin
            failCount++;
            $error("done stayed high for more than one cycle");
        end

    // Program has ended when done rises
    doneNotBusy: assert property (@(posedge clk) disable iff (!arstN) !(done && busy))
        else begin
            failCount++;
            $error("done and busy high together");
        end

    // Column writes only inside a run and never in its last cycle
    writeInRun: assert property (@(posedge clk) disable iff (!arstN)
                                 writeEn |-> busy ##1 busy)
        else begin
            failCount++;
            $error("bank write outside a running program");
        end

    // Sticky flag cleared by the start that resumes
    illegalIdle: assert property (@(posedge clk) disable iff (!arstN) illegalOp |-> !busy)
        else begin
            failCount++;
            $error("illegalOp high while busy");
        end

endmodule

// Attached to every sequencer instance
bind commandSequencer matrixUnitAsserts seqChecks (
    .clk       (clk),
    .arstN     (arstN),
    .busy      (busy),
    .done      (done),
    .illegalOp (illegalOp),
    .writeEn   (writePort.writeEn)
);

/* bench/matrixUnitTb.sv */
module matrixUnitTb import matrixPkg::*; ();

    // About four times the length of all tests
    localparam int timeoutCycles = 2000;

    logic                    clk;
    logic                    arstN;
    logic                    progWrite;
    logic [memAddrWidth-1:0] progAddr;
    logic [wordWidth-1:0]    progData;
    logic                    start;
    logic                    busy;
    logic                    done;
    logic                    illegalOp;
    matrixSel_e              rdSel;
    logic [1:0]              rdRow;
    logic [1:0]              rdCol;
    logic [wordWidth-1:0]    rdData;

    // Reference copy of both matrices by matrix, row and column
    logic [wordWidth-1:0] expMat [2][matrixDim][matrixDim];
    // Program being built and the LoadMatrix payload
    logic [wordWidth-1:0] progWords [$];
    logic [wordWidth-1:0] payload [matrixDim*matrixDim];
    logic [wordWidth-1:0] prevPayload [matrixDim*matrixDim];
    int                   runCycles;
    int                   cycleCount = 0;

    matrixUnitTop uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    // Bound checker failures end the run at once
    always @(uut.uSequencer.seqChecks.failCount) begin
        if (uut.uSequencer.seqChecks.failCount != 0) begin
            $display("Assertion failure in the sequencer checker");
            $display("ERRORS FOUND");
            $fatal(1, "assertion failure");
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
        if (actual !== expected) begin
            $display("FAIL %0t: %s, got %h, expected %h", $time, msg, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    // Command words built from the opcode table
    function automatic logic [31:0] modeCmd(input matrixSel_e sel);
        return 32'(opMatrixMode) | (32'(sel) << 8);
    endfunction

    // Sixteen fresh random words followed by command and payload
    task automatic appendLoad();
        for (int i = 0; i < matrixDim * matrixDim; i++) begin
            payload[i] = $urandom();
        end
        progWords.push_back(32'h8000_0000 | 32'(opLoadMatrix));
        for (int i = 0; i < matrixDim * matrixDim; i++) begin
            progWords.push_back(payload[i]);
        end
    endtask

    // Payload is column major
    task automatic applyLoad(input int m);
        for (int c = 0; c < matrixDim; c++) begin
            for (int r = 0; r < matrixDim; r++) begin
                expMat[m][r][c] = payload[matrixDim * c + r];
            end
        end
    endtask

    task automatic applyIdentity(input int m);
        for (int r = 0; r < matrixDim; r++) begin
            for (int c = 0; c < matrixDim; c++) begin
                expMat[m][r][c] = (r == c) ? floatOne : '0;
            end
        end
    endtask

    task automatic writeProgram();
        for (int i = 0; i < progWords.size(); i++) begin
            @(posedge clk);
            progWrite <= 1'b1;
            progAddr  <= memAddrWidth'(i);
            progData  <= progWords[i];
        end
        @(posedge clk);
        progWrite <= 1'b0;
    endtask

    // Count from the start edge to the edge that raises done
    task automatic runProgram();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        runCycles = 1;
        @(negedge clk);
        checkValue(busy, 1, "busy after start");
        while (!done) begin
            @(posedge clk);
            runCycles++;
            @(negedge clk);
        end
    endtask

    // Every element of both matrices against the reference copy
    task automatic checkMatrices();
        for (int m = 0; m < 2; m++) begin
            for (int r = 0; r < matrixDim; r++) begin
                for (int c = 0; c < matrixDim; c++) begin
                    @(posedge clk);
                    rdSel <= matrixSel_e'(m);
                    rdRow <= 2'(r);
                    rdCol <= 2'(c);
                    @(negedge clk);
                    checkValue(rdData, expMat[m][r][c],
                               $sformatf("matrix %0d row %0d col %0d", m, r, c));
                end
            end
        end
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic resetTest();
        @(negedge clk);
        checkValue(busy, 0, "busy after reset");
        checkValue(done, 0, "done after reset");
        checkValue(illegalOp, 0, "illegalOp after reset");
        checkMatrices();
    endtask

    task automatic loadMatrixTest();
        progWords.delete();
        progWords.push_back(modeCmd(selModelview));
        appendLoad();
        progWords.push_back(32'(opHalt));
        writeProgram();
        runProgram();
        // Start, MatrixMode, LoadMatrix, Halt
        checkValue(runCycles, 1 + 1 + 5 + 1, "LoadMatrix program cycles");
        checkValue(illegalOp, 0, "illegalOp after LoadMatrix");
        applyLoad(selModelview);
        checkMatrices();
    endtask

    task automatic selectTest();
        progWords.delete();
        progWords.push_back(modeCmd(selProjection));
        appendLoad();
        progWords.push_back(modeCmd(selModelview));
        progWords.push_back(32'(opLoadIdentity));
        progWords.push_back(32'(opHalt));
        writeProgram();
        runProgram();
        checkValue(runCycles, 1 + 1 + 5 + 1 + 5 + 1, "select program cycles");
        applyLoad(selProjection);
        applyIdentity(selModelview);
        checkMatrices();
    endtask

    task automatic illegalTest();
        // LoadIdentity after the bad word must not run
        progWords.delete();
        progWords.push_back(modeCmd(selProjection));
        progWords.push_back(32'h0000_007F);
        progWords.push_back(32'(opLoadIdentity));
        progWords.push_back(32'(opHalt));
        writeProgram();
        runProgram();
        checkValue(runCycles, 1 + 1 + 1, "illegal program cycles");
        checkValue(illegalOp, 1, "illegalOp with done");
        repeat (3) @(negedge clk);
        checkValue(illegalOp, 1, "illegalOp sticky");
        checkValue(busy, 0, "busy after illegal opcode");
        checkMatrices();
        // Select from the first word still holds
        progWords.delete();
        progWords.push_back(32'(opLoadIdentity));
        progWords.push_back(32'(opHalt));
        writeProgram();
        runProgram();
        checkValue(runCycles, 1 + 5 + 1, "identity program cycles");
        checkValue(illegalOp, 0, "illegalOp after restart");
        applyIdentity(selProjection);
        checkMatrices();
    endtask

    task automatic reloadTest();
        for (int pass = 0; pass < 2; pass++) begin
            progWords.delete();
            progWords.push_back(modeCmd(selModelview));
            appendLoad();
            progWords.push_back(32'(opHalt));
            // Second pass must differ in every word
            for (int i = 0; i < matrixDim * matrixDim; i++) begin
                if (pass == 1 && payload[i] == prevPayload[i]) begin
                    payload[i]     = ~prevPayload[i];
                    progWords[i+2] = payload[i];
                end
                prevPayload[i] = payload[i];
            end
            writeProgram();
            runProgram();
            applyLoad(selModelview);
            checkMatrices();
        end
    endtask

    initial begin
        void'($urandom(32'hbf3d));
        arstN     = 1'b0;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        start     = 1'b0;
        rdSel     = selModelview;
        rdRow     = '0;
        rdCol     = '0;
        for (int m = 0; m < 2; m++) begin
            for (int r = 0; r < matrixDim; r++) begin
                for (int c = 0; c < matrixDim; c++) begin
                    expMat[m][r][c] = '0;
                end
            end
        end
        repeat (10) @(posedge clk);
        arstN <= 1'b1;

        resetTest();
        loadMatrixTest();
        selectTest();
        illegalTest();
        reloadTest();

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* sources.f */
source/matrixPkg.sv
source/matrixWriteIf.sv
source/commandMemory.sv
source/commandSequencer.sv
source/matrixBank.sv
source/matrixUnitTop.sv
bench/matrixUnit_asserts.sv
bench/matrixUnitTb.sv

/* Bender.yml */
package:
  name: matrixUnit

sources:
  - source/matrixPkg.sv
  - source/matrixWriteIf.sv
  - source/commandMemory.sv
  - source/commandSequencer.sv
  - source/matrixBank.sv
  - source/matrixUnitTop.sv
  - target: test
    files:
      - bench/matrixUnit_asserts.sv
      - bench/matrixUnitTb.sv
